/* build.f */
src/vid_pkg.sv
src/vram.sv
src/video_timing.sv
src/vram_arbiter.sv
src/pixel_fetch.sv
src/video_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the video testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* bench/tb_top.sv */
// ******************************
// video testbench top
// dut, seeded host stimulus in
// three phases, watchdog
// ******************************

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_ACTIVE     = 32;
    localparam int H_TOTAL      = 40;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_LEN   = 4;
    localparam int V_ACTIVE     = 8;
    localparam int V_TOTAL      = 12;
    localparam int V_SYNC_START = 9;
    localparam int V_SYNC_LEN   = 2;
    localparam int VRAM_AW      = 12;
    localparam int CLK_PERIOD   = 8;
    localparam int unsigned SEED = 32'hdb3d_36b5;

    localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;
    localparam int FRAME_WORDS  = V_ACTIVE * H_ACTIVE / 4;
    localparam int N_MIXED      = 400;
    localparam int A_CYC        = FRAME_WORDS * 4;      // busy wait, strobe and gap
    localparam int B_CYC        = 3 * FRAME_CYC + 8;
    localparam int C_CYC        = N_MIXED * 4;
    localparam int WATCHDOG_CYC = A_CYC + B_CYC + C_CYC + 3 * FRAME_CYC;

    logic            clk;
    logic            rst_n;
    logic            host_wr;
    logic            host_rd;
    vid_pkg::vaddr_t host_addr;
    vid_pkg::vword_t host_wdata;
    logic            host_busy;
    vid_pkg::vword_t host_rdata;
    logic            host_rd_valid;
    vid_pkg::pix_t   pix;
    logic            pix_valid;
    logic            hsync;
    logic            vsync;
    logic            pix_chk;       // pixel values compared while high
    vid_pkg::vaddr_t last_wr_addr;
    int              err_total;

    tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(8)) u_clk (.clk(clk), .rst_n(rst_n));

    video_top #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN),
        .VRAM_AW(VRAM_AW)
    ) u_dut (.*);

    tb_checker #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN),
        .VRAM_AW(VRAM_AW)
    ) u_chk (.*);

    // called on a falling edge and returns on one
    task automatic host_access(input logic wr, input vid_pkg::vaddr_t addr,
                               input vid_pkg::vword_t data);
        while (host_busy) @(negedge clk);
        host_wr    = wr;
        host_rd    = !wr;
        host_addr  = addr;
        host_wdata = data;
        @(negedge clk);
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = vid_pkg::vaddr_t'($urandom);   // meaningless without a strobe
        host_wdata = vid_pkg::vword_t'($urandom);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic vid_pkg::vaddr_t rand_addr(input int range);
        return vid_pkg::vaddr_t'($urandom_range(range - 1));
    endfunction

    initial begin
        time b_end;
        void'($urandom(SEED));
        host_wr      = 1'b0;
        host_rd      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        pix_chk      = 1'b0;
        last_wr_addr = '0;
        @(posedge rst_n);
        @(negedge clk);

        // phase A fills the visible frame
        for (int i = 0; i < FRAME_WORDS; i++) begin
            host_access(1'b1, vid_pkg::vaddr_t'(i), vid_pkg::vword_t'($urandom));
            idle($urandom_range(1));
        end

        // phase B settles one frame and then only reads while pixels are checked
        idle(FRAME_CYC);
        pix_chk = 1'b1;
        b_end   = $time + 2 * FRAME_CYC * CLK_PERIOD;
        while ($time < b_end) begin
            if ($urandom_range(3) == 0) begin
                host_access(1'b0, rand_addr(FRAME_WORDS), '0);
            end else begin
                idle(1);
            end
        end
        pix_chk = 1'b0;

        // phase C mixes traffic over the whole ram
        for (int i = 0; i < N_MIXED; i++) begin
            if ($urandom_range(1) == 1) begin
                last_wr_addr = rand_addr(1 << VRAM_AW);
                host_access(1'b1, last_wr_addr, vid_pkg::vword_t'($urandom));
            end else if ($urandom_range(1) == 1) begin
                host_access(1'b0, last_wr_addr, '0);    // read back the latest write
            end else begin
                host_access(1'b0, rand_addr(1 << VRAM_AW), '0);
            end
            idle($urandom_range(1));
        end

        idle(8);    // let the last reads return
        u_chk.print_summary(err_total);
        if (err_total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Test failed");
        $finish;
    end

endmodule

/* bench/tb_checker.sv */
// ******************************
// testbench checker
// memory and raster model, read
// data, pixel, sync and busy checks
// ******************************

module tb_checker #(
    parameter int H_ACTIVE     = 32,
    parameter int H_TOTAL      = 40,
    parameter int H_SYNC_START = 34,
    parameter int H_SYNC_LEN   = 4,
    parameter int V_ACTIVE     = 8,
    parameter int V_TOTAL      = 12,
    parameter int V_SYNC_START = 9,
    parameter int V_SYNC_LEN   = 2,
    parameter int VRAM_AW      = 12
) (
    input logic            clk,
    input logic            rst_n,
    input logic            host_wr,
    input logic            host_rd,
    input vid_pkg::vaddr_t host_addr,
    input vid_pkg::vword_t host_wdata,
    input logic            host_busy,
    input vid_pkg::vword_t host_rdata,
    input logic            host_rd_valid,
    input vid_pkg::pix_t   pix,
    input logic            pix_valid,
    input logic            hsync,
    input logic            vsync,
    input logic            pix_chk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS_PER_LINE = H_ACTIVE / 4;
    localparam int DEPTH          = 1 << VRAM_AW;

    vid_pkg::vword_t mem_model [0:DEPTH-1];
    bit              known [0:DEPTH-1];    // word written by the host
    vid_pkg::vword_t exp_q [$];
    bit              chk_q [$];
    longint          issue_q [$];           // strobe cycle of each read
    longint          cycle;
    int              errors = 0;
    int              checks = 0;
    int              h;
    int              v;
    int              h_d1;
    int              v_d1;
    int              h_d2;
    int              v_d2;
    int              fill;                  // depth of valid positions in the pipe
    logic            take_prev;
    logic            fetch_prev;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            known[i] = 1'b0;
        end
    end

    task automatic failure(input string what);
        errors++;
        $display("%0t ns: %s", $time, what);
    endtask

    task automatic compare(input string what, input int got, input int want);
        checks++;
        if (got != want) begin
            errors++;
            $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        logic            exp_act;
        logic            take;
        int              a;
        vid_pkg::vword_t word;
        longint          lat;
        if (!rst_n) begin
            h          = 0;
            v          = 0;
            fill       = 0;
            cycle      = 0;
            take_prev  = 1'b0;
            fetch_prev = 1'b0;
        end else begin
            exp_act = (fill == 2) && (h_d2 < H_ACTIVE) && (v_d2 < V_ACTIVE);
            compare("pix_valid", int'(pix_valid), int'(exp_act));
            compare("hsync", int'(hsync), int'((fill == 2) && (h_d2 >= H_SYNC_START) &&
                                               (h_d2 < H_SYNC_START + H_SYNC_LEN)));
            compare("vsync", int'(vsync), int'((fill == 2) && (v_d2 >= V_SYNC_START) &&
                                               (v_d2 < V_SYNC_START + V_SYNC_LEN)));
            compare("host_busy", int'(host_busy), int'(take_prev && fetch_prev));

            // msn of the word is the leftmost pixel
            a = v_d2 * WORDS_PER_LINE + h_d2 / 4;
            if (pix_chk && exp_act && known[a]) begin
                word = mem_model[a] >> (4 * (3 - h_d2 % 4));
                compare($sformatf("pix at (%0d,%0d)", h_d2, v_d2), int'(pix), int'(word[3:0]));
            end else if (pix_chk && exp_act) begin
                failure("pixel shown from a word the host never wrote");
            end

            if (host_rd_valid && exp_q.size() == 0) begin
                failure("read data returned with no read outstanding");
            end else if (host_rd_valid) begin
                lat  = cycle - issue_q.pop_front();
                word = exp_q.pop_front();
                if (lat < 1 || lat > 2) begin
                    failure($sformatf("host read took %0d cycles", lat));
                end
                if (chk_q.pop_front()) begin
                    compare("host_rdata", int'(host_rdata), int'(word));
                end
            end

            take = (host_wr || host_rd) && !host_busy;
            a    = int'(host_addr[VRAM_AW-1:0]);
            if (take && host_wr) begin
                mem_model[a] = host_wdata;
                known[a]     = 1'b1;
            end
            if (take && host_rd) begin
                exp_q.push_back(mem_model[a]);
                chk_q.push_back(known[a]);
                issue_q.push_back(cycle);
            end

            take_prev  = take;
            fetch_prev = (h % 4 == 0) && (h < H_ACTIVE) && (v < V_ACTIVE);
            h_d2 = h_d1;
            v_d2 = v_d1;
            h_d1 = h;
            v_d1 = v;
            if (fill < 2) fill++;
            if (h == H_TOTAL - 1) begin
                h = 0;
                v = (v == V_TOTAL - 1) ? 0 : v + 1;
            end else begin
                h++;
            end
            cycle++;
        end
    end

    task automatic print_summary(output int total);
        if (exp_q.size() != 0) begin
            failure($sformatf("%0d host reads never returned data", exp_q.size()));
        end
        $display("checks %0d, errors %0d", checks, errors);
        total = errors;
    endtask

endmodule

/* bench/tb_clock.sv */
// ******************************
// testbench clock and reset
// ******************************

module tb_clock #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);     // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

/* src/video_top.sv */
// ******************************
// video subsystem top level
// timing, fetch, arbiter, vram
// ******************************

module video_top #(
    parameter int H_ACTIVE     = 640,
    parameter int H_TOTAL      = 800,
    parameter int H_SYNC_START = 656,
    parameter int H_SYNC_LEN   = 96,
    parameter int V_ACTIVE     = 480,
    parameter int V_TOTAL      = 525,
    parameter int V_SYNC_START = 490,
    parameter int V_SYNC_LEN   = 2,
    parameter int VRAM_AW      = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            host_wr,
    input  logic            host_rd,
    input  vid_pkg::vaddr_t host_addr,
    input  vid_pkg::vword_t host_wdata,
    output logic            host_busy,
    output vid_pkg::vword_t host_rdata,
    output logic            host_rd_valid,
    output vid_pkg::pix_t   pix,
    output logic            pix_valid,
    output logic            hsync,
    output logic            vsync
);

    vid_pkg::coord_t h_count;
    vid_pkg::coord_t v_count;
    logic            active;
    logic            hsync_raw;
    logic            vsync_raw;
    logic            fetch_req;
    vid_pkg::vaddr_t fetch_addr;
    vid_pkg::vword_t fetch_data;
    logic            mem_sel;
    logic            mem_wr_en;
    vid_pkg::vaddr_t mem_addr;
    vid_pkg::vword_t mem_wdata;
    vid_pkg::vword_t mem_rdata;

    video_timing #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN)
    ) u_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .h_count   (h_count),
        .v_count   (v_count),
        .active    (active),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw)
    );

    pixel_fetch #(
        .H_ACTIVE (H_ACTIVE)
    ) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .h_count    (h_count),
        .v_count    (v_count),
        .active     (active),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    vram_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_data    (fetch_data),
        .host_wr       (host_wr),
        .host_rd       (host_rd),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_busy     (host_busy),
        .host_rdata    (host_rdata),
        .host_rd_valid (host_rd_valid),
        .mem_sel       (mem_sel),
        .mem_wr_en     (mem_wr_en),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata)
    );

    vram #(
        .VRAM_AW (VRAM_AW)
    ) u_vram (
        .clk   (clk),
        .sel   (mem_sel),
        .wr_en (mem_wr_en),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* src/pixel_fetch.sv */
// ******************************
// pixel fetch and unpack
// word addresses, nibble shifter,
// sync and blank alignment
// ******************************

module pixel_fetch #(
    parameter int H_ACTIVE = 640
) (
    input  logic            clk,
    input  logic            rst_n,
    input  vid_pkg::coord_t h_count,
    input  vid_pkg::coord_t v_count,
    input  logic            active,
    input  logic            hsync_raw,
    input  logic            vsync_raw,
    output logic            fetch_req,
    output vid_pkg::vaddr_t fetch_addr,
    input  vid_pkg::vword_t fetch_data,
    output vid_pkg::pix_t   pix,
    output logic            pix_valid,
    output logic            hsync,
    output logic            vsync
);

    localparam int WORDS_PER_LINE = H_ACTIVE / 4;

    logic            fetch_d1;       // fetch_data carries our word this cycle
    vid_pkg::vword_t shift_q;        // pixels of the current word, msn first
    logic [1:0]      active_pipe;
    logic [1:0]      hsync_pipe;
    logic [1:0]      vsync_pipe;

    // one word covers four pixels
    assign fetch_req  = active && (h_count[1:0] == 2'b00);
    assign fetch_addr = vid_pkg::vaddr_t'(v_count * WORDS_PER_LINE) +
                        vid_pkg::vaddr_t'(h_count >> 2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_d1    <= 1'b0;
            active_pipe <= '0;
            hsync_pipe  <= '0;
            vsync_pipe  <= '0;
        end else begin
            fetch_d1    <= fetch_req;
            active_pipe <= {active_pipe[0], active};
            hsync_pipe  <= {hsync_pipe[0], hsync_raw};
            vsync_pipe  <= {vsync_pipe[0], vsync_raw};
        end
    end

    // load lands exactly as the previous word runs out
    always_ff @(posedge clk) begin
        if (fetch_d1) begin
            shift_q <= fetch_data;
        end else begin
            shift_q <= {shift_q[11:0], 4'h0};
        end
    end

    assign pix       = shift_q[15:12];
    assign pix_valid = active_pipe[1];  // stage one plus two cycles
    assign hsync     = hsync_pipe[1];
    assign vsync     = vsync_pipe[1];

endmodule

/* src/vram_arbiter.sv */
// ******************************
// vram port arbiter
// raster fetch first, host second,
// one pending host access
// ******************************

module vram_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_req,
    input  vid_pkg::vaddr_t fetch_addr,
    output vid_pkg::vword_t fetch_data,
    input  logic            host_wr,
    input  logic            host_rd,
    input  vid_pkg::vaddr_t host_addr,
    input  vid_pkg::vword_t host_wdata,
    output logic            host_busy,
    output vid_pkg::vword_t host_rdata,
    output logic            host_rd_valid,
    output logic            mem_sel,
    output logic            mem_wr_en,
    output vid_pkg::vaddr_t mem_addr,
    output vid_pkg::vword_t mem_wdata,
    input  vid_pkg::vword_t mem_rdata
);

    logic            host_req;       // strobe taken this cycle
    logic            host_rd_issue;  // a host read goes to the ram now
    logic            pend_valid_q;
    logic            pend_wr_q;      // kind of the waiting access
    vid_pkg::vaddr_t pend_addr_q;
    vid_pkg::vword_t pend_wdata_q;
    logic            host_owner_q;   // last ram read belongs to the host

    assign host_req  = (host_wr || host_rd) && !pend_valid_q;
    assign host_busy = pend_valid_q;

    // a fetch never follows a fetch, so the pending slot always drains next cycle
    assign host_rd_issue = !fetch_req && ((pend_valid_q && !pend_wr_q) || (host_req && host_rd));

    always_comb begin
        mem_sel   = fetch_req || pend_valid_q || host_req;
        mem_wdata = pend_valid_q ? pend_wdata_q : host_wdata;
        if (fetch_req) begin
            mem_wr_en = 1'b0;
            mem_addr  = fetch_addr;
        end else if (pend_valid_q) begin
            mem_wr_en = pend_wr_q;
            mem_addr  = pend_addr_q;
        end else begin
            mem_wr_en = host_wr;    // sel is low without a strobe
            mem_addr  = host_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid_q <= 1'b0;
            host_owner_q <= 1'b0;
        end else begin
            pend_valid_q <= fetch_req && host_req;  // collided, wait one slot
            host_owner_q <= host_rd_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req && host_req) begin
            pend_wr_q    <= host_wr;
            pend_addr_q  <= host_addr;
            pend_wdata_q <= host_wdata;
        end
    end

    // returning word goes to both sides, the owner bit qualifies the host copy
    assign fetch_data    = mem_rdata;
    assign host_rdata    = mem_rdata;
    assign host_rd_valid = host_owner_q;

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
        host_busy |-> !(host_wr || host_rd));

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_wr && host_rd));

    // the pending slot relies on this spacing
    a_fetch_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req |=> !fetch_req);

endmodule

/* src/video_timing.sv */
// ******************************
// raster timing
// h and v counters, sync pulses,
// active area flag
// ******************************

module video_timing #(
    parameter int H_ACTIVE     = 640,
    parameter int H_TOTAL      = 800,
    parameter int H_SYNC_START = 656,
    parameter int H_SYNC_LEN   = 96,
    parameter int V_ACTIVE     = 480,
    parameter int V_TOTAL      = 525,
    parameter int V_SYNC_START = 490,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    output vid_pkg::coord_t h_count,
    output vid_pkg::coord_t v_count,
    output logic            active,
    output logic            hsync_raw,
    output logic            vsync_raw
);

    localparam int H_SYNC_END = H_SYNC_START + H_SYNC_LEN;
    localparam int V_SYNC_END = V_SYNC_START + V_SYNC_LEN;

    vid_pkg::raster_state_t state;
    vid_pkg::raster_state_t state_next;
    vid_pkg::coord_t        v_next;
    logic                   h_wrap;     // last pixel of the line

    assign h_wrap = (h_count == vid_pkg::coord_t'(H_TOTAL - 1));
    assign v_next = (v_count == vid_pkg::coord_t'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;

    // vertical phase only moves at end of line
    always_comb begin
        state_next = state;
        if (h_wrap) begin
            case (state)
                vid_pkg::rs_active: begin
                    if (v_next == vid_pkg::coord_t'(V_ACTIVE)) begin
                        // zero-length front porch goes straight to sync
                        state_next = (V_SYNC_START == V_ACTIVE) ? vid_pkg::rs_sync
                                                                : vid_pkg::rs_front;
                    end
                end
                vid_pkg::rs_front: begin
                    if (v_next == vid_pkg::coord_t'(V_SYNC_START)) begin
                        state_next = vid_pkg::rs_sync;
                    end
                end
                vid_pkg::rs_sync: begin
                    if (v_next == '0) begin
                        state_next = vid_pkg::rs_active;
                    end else if (v_next == vid_pkg::coord_t'(V_SYNC_END)) begin
                        state_next = vid_pkg::rs_back;
                    end
                end
                vid_pkg::rs_back: begin
                    if (v_next == '0) begin
                        state_next = vid_pkg::rs_active;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
            state   <= vid_pkg::rs_active;  // line 0 is visible
        end else begin
            state <= state_next;
            if (h_wrap) begin
                h_count <= '0;
                v_count <= v_next;
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    assign active    = (h_count < vid_pkg::coord_t'(H_ACTIVE)) && (state == vid_pkg::rs_active);
    assign hsync_raw = (h_count >= vid_pkg::coord_t'(H_SYNC_START)) &&
                       (h_count < vid_pkg::coord_t'(H_SYNC_END));
    assign vsync_raw = (state == vid_pkg::rs_sync);

    a_h_range: assert property (@(posedge clk) disable iff (!rst_n)
        h_count < vid_pkg::coord_t'(H_TOTAL));

    // fsm must agree with the line counter
    a_state_track: assert property (@(posedge clk) disable iff (!rst_n)
        (state == vid_pkg::rs_active) == (v_count < vid_pkg::coord_t'(V_ACTIVE)));

endmodule

/* src/vram.sv */
// ******************************
// single-port video ram
// synchronous write, registered
// read-before-write output
// ******************************

module vram #(
    parameter int VRAM_AW = 16
) (
    input  logic            clk,
    input  logic            sel,
    input  logic            wr_en,
    input  vid_pkg::vaddr_t addr,
    input  vid_pkg::vword_t wdata,
    output vid_pkg::vword_t rdata
);

    localparam int DEPTH = 1 << VRAM_AW;

    vid_pkg::vword_t        mem [0:DEPTH-1];
    logic [VRAM_AW-1:0]     word_addr;      // only the implemented address bits

    assign word_addr = addr[VRAM_AW-1:0];

    // recognisable garbage so unwritten words stand out in waves
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 16'hdead;
        end
    end

    // old contents come out on a write cycle
    always_ff @(posedge clk) begin
        if (sel) begin
            if (wr_en) begin
                mem[word_addr] <= wdata;
            end
            rdata <= mem[word_addr];    // one cycle after sel
        end
    end

endmodule

/* src/vid_pkg.sv */
// ******************************
// shared video types
// word, pixel, address and counter
// widths, raster state enum
// ******************************

package vid_pkg;

    // one vram word holds four 4-bit pixels
    typedef logic [15:0] vword_t;

    // palette index of one pixel
    typedef logic [3:0] pix_t;

    // full-width word address, smaller rams use the low bits
    typedef logic [15:0] vaddr_t;

    // h or v raster position
    typedef logic [9:0] coord_t;

    // vertical phase of the raster
    typedef enum logic [1:0] {
        rs_active = 2'd0,   // visible lines
        rs_front  = 2'd1,   // front porch
        rs_sync   = 2'd2,   // vsync lines
        rs_back   = 2'd3    // back porch
    } raster_state_t;

endpackage
